//--- src/u1e_ctrl_config.svh
// u1e control core configuration: slave map, setting indices, misc offsets
`ifndef U1E_CTRL_CONFIG_SVH
`define U1E_CTRL_CONFIG_SVH

//////////////////////////////////////////////////
// wishbone slave numbers, taken from adr[10:7]
`define U1E_SLV_MISC      4'h0
`define U1E_SLV_RB        4'h7
`define U1E_SLV_SET       4'h8
`define U1E_SLV_SET_MASK  4'hE   // settings slave spans 8 and 9

//////////////////////////////////////////////////
// setting register indices
`define SR_TIME64         42     // time load high word, low word at +1
`define SR_REG_TEST32     60

//////////////////////////////////////////////////
// misc register byte offsets
`define REG_LEDS          7'd0
`define REG_CGEN_CTRL     7'd4
`define REG_CGEN_ST       7'd6   // read only
`define REG_TEST          7'd8
`define REG_RX_FRAMELEN   7'd10  // read only
`define REG_TX_FRAMELEN   7'd12
`define REG_XFER_RATE     7'd14
`define REG_COMPAT        7'd16  // read only

`define COMPAT_NUM        8'd5
`define RB_DEFAULT        16'hBEEF

`endif

//--- src/ctrl_bus_pkg.sv
// control bus package: wishbone side address, data and slave index types
package ctrl_bus_pkg;

   // byte address from the single master
   typedef logic [10:0] wb_adr_t;

   // 16 bit data in both directions
   typedef logic [15:0] wb_dat_t;

   // slave number, upper four address bits
   typedef logic [3:0]  slave_idx_t;

endpackage

//--- src/ctrl_regs_pkg.sv
// control register package: settings bus, time and readback types
package ctrl_regs_pkg;

   // 64 setting registers of 32 bits
   typedef logic [5:0]  set_adr_t;
   typedef logic [31:0] set_dat_t;

   typedef logic [63:0] vita_time_t;   // free running time count

   typedef logic [31:0] rb_word_t;     // one readback word, seen as two halves

   // misc slave register
   typedef logic [15:0] misc_reg_t;

endpackage

//--- src/setting_reg.sv
// setting register: captures the settings bus word at its own index
module setting_reg
   import ctrl_regs_pkg::*;
#(
   parameter int my_addr = 0,
   parameter int width   = 32
)
(
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  logic             set_stb_i,
   input  set_adr_t         set_adr_i,
   input  set_dat_t         set_dat_i,
   output logic [width-1:0] out_o,
   output logic             changed_o
);
   logic hit;

   assign hit = set_stb_i & (set_adr_i == set_adr_t'(my_addr));

   always_ff @(posedge wb_clk)
   begin
      if (hit)
         out_o <= set_dat_i[width-1:0];
   end

   // one cycle pulse, lines up with the new out value
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         changed_o <= 1'b0;
      else
         changed_o <= hit;
   end

endmodule

//--- src/wb_slave_decode.sv
// wishbone slave decoder with read data and ack return for the single master
`include "u1e_ctrl_config.svh"

module wb_slave_decode
   import ctrl_bus_pkg::*;
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  logic    cyc_i,
   input  logic    stb_i,
   input  wb_adr_t adr_i,
   input  wb_dat_t misc_dat_i,
   input  logic    misc_ack_i,
   input  wb_dat_t rb_dat_i,
   input  logic    rb_ack_i,
   input  logic    set_ack_i,
   output logic    misc_stb_o,
   output logic    rb_stb_o,
   output logic    set_stb_o,
   output wb_dat_t dat_o,
   output logic    ack_o
);
   slave_idx_t slv;
   logic       ack_q;   // ack given in the previous cycle
   logic       req;
   logic       hit_misc, hit_rb, hit_set;

   assign slv = adr_i[10:7];

   // one idle cycle after every ack keeps settings strobes apart
   assign req = cyc_i & stb_i & ~ack_q;

   assign hit_misc = (slv == `U1E_SLV_MISC);
   assign hit_rb   = (slv == `U1E_SLV_RB);
   assign hit_set  = ((slv & `U1E_SLV_SET_MASK) == (`U1E_SLV_SET & `U1E_SLV_SET_MASK));

   assign misc_stb_o = req & hit_misc;
   assign rb_stb_o   = req & hit_rb;
   assign set_stb_o  = req & hit_set;

   // unmapped slaves give 0 and never ack
   always_comb
   begin
      dat_o = '0;
      ack_o = 1'b0;
      if (hit_misc)
      begin
         dat_o = misc_dat_i;
         ack_o = misc_ack_i;
      end
      else if (hit_rb)
      begin
         dat_o = rb_dat_i;
         ack_o = rb_ack_i;
      end
      else if (hit_set)
         ack_o = set_ack_i;   // write only, reads return 0
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= ack_o;
   end

endmodule

//--- src/misc_regs.sv
// misc register slave: leds, clock generator control and status, frame lengths
`include "u1e_ctrl_config.svh"

module misc_regs
   import ctrl_bus_pkg::*, ctrl_regs_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       stb_i,
   input  logic       we_i,
   input  wb_adr_t    adr_i,
   input  wb_dat_t    dat_i,
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   input  misc_reg_t  rx_frame_len_i,
   output wb_dat_t    dat_o,
   output logic       ack_o,
   output logic [3:0] debug_led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output misc_reg_t  tx_frame_len_o,
   output logic [7:0] test_rate_o,
   output logic [3:0] test_ctrl_o
);
   misc_reg_t  reg_leds, reg_cgen_ctrl, reg_test, xfer_rate;
   logic [6:0] offset;

   assign offset = adr_i[6:0];
   assign ack_o  = stb_i;   // no wait states

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds       <= '0;
         reg_cgen_ctrl  <= 16'd3;   // sync_b and ref_sel idle high
         reg_test       <= '0;
         tx_frame_len_o <= '0;
         xfer_rate      <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (offset)
            `REG_LEDS:        reg_leds       <= dat_i;
            `REG_CGEN_CTRL:   reg_cgen_ctrl  <= dat_i;
            `REG_TEST:        reg_test       <= dat_i;
            `REG_TX_FRAMELEN: tx_frame_len_o <= dat_i;
            `REG_XFER_RATE:   xfer_rate      <= dat_i;
            default:          ;
         endcase
      end
   end

   always_comb
   begin
      case (offset)
         `REG_LEDS:        dat_o = reg_leds;
         `REG_CGEN_CTRL:   dat_o = reg_cgen_ctrl;
         `REG_CGEN_ST:     dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `REG_TEST:        dat_o = reg_test;
         `REG_RX_FRAMELEN: dat_o = rx_frame_len_i;
         `REG_TX_FRAMELEN: dat_o = tx_frame_len_o;
         `REG_XFER_RATE:   dat_o = xfer_rate;
         `REG_COMPAT:      dat_o = {8'd0, `COMPAT_NUM};
         default:          dat_o = `RB_DEFAULT;
      endcase
   end

   assign test_ctrl_o = xfer_rate[11:8];
   assign test_rate_o = xfer_rate[7:0];
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];
   assign debug_led_o = ~reg_leds[3:0];   // leds are active low

endmodule

//--- src/settings_bus_16le.sv
// settings bus bridge: two 16 bit wishbone writes make one 32 bit setting strobe
module settings_bus_16le
   import ctrl_bus_pkg::*, ctrl_regs_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     stb_i,
   input  logic     we_i,
   input  wb_adr_t  adr_i,
   input  wb_dat_t  dat_i,
   output logic     ack_o,
   output logic     set_stb_o,
   output set_adr_t set_adr_o,
   output set_dat_t set_dat_o
);
   wb_dat_t low_half;   // held until the high half arrives
   logic    wr;

   assign wr    = stb_i & we_i;
   assign ack_o = stb_i;   // reads ack too, data comes back as 0

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr & adr_i[1];
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr & ~adr_i[1])
         low_half <= dat_i;
      if (wr & adr_i[1])
      begin
         set_adr_o <= adr_i[7:2];
         set_dat_o <= {dat_i, low_half};
      end
   end

endmodule

//--- src/time_64bit.sv
// vita time: 64 bit cycle counter with settings bus load and pps capture
`include "u1e_ctrl_config.svh"

module time_64bit
   import ctrl_regs_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       set_stb_i,
   input  set_adr_t   set_adr_i,
   input  set_dat_t   set_dat_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);
   set_dat_t   time_hi, time_lo;
   logic       load;       // low word written, takes both words
   logic [1:0] pps_sync;
   logic       pps_d;
   logic       pps_rise;

   setting_reg #(.my_addr(`SR_TIME64), .width(32)) sr_time_hi
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_adr_i(set_adr_i), .set_dat_i(set_dat_i),
      .out_o(time_hi), .changed_o()
   );

   setting_reg #(.my_addr(`SR_TIME64 + 1), .width(32)) sr_time_lo
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_adr_i(set_adr_i), .set_dat_i(set_dat_i),
      .out_o(time_lo), .changed_o(load)
   );

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (load)
         vita_time_o <= {time_hi, time_lo};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   // pps is asynchronous to wb_clk
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_d;

   always_ff @(posedge wb_clk)
   begin
      if (pps_rise)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

//--- src/readback_mux_16le.sv
// readback slave: 32 bit status words read as little endian 16 bit halves
module readback_mux_16le
   import ctrl_bus_pkg::*, ctrl_regs_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     stb_i,
   input  wb_adr_t  adr_i,
   input  rb_word_t word00_i,
   input  rb_word_t word01_i,
   input  rb_word_t word02_i,
   input  rb_word_t word03_i,
   input  rb_word_t word04_i,
   input  rb_word_t word05_i,
   output wb_dat_t  dat_o,
   output logic     ack_o
);
   rb_word_t word_sel;

   always_comb
   begin
      case (adr_i[5:2])
         4'd0:    word_sel = word00_i;
         4'd1:    word_sel = word01_i;
         4'd2:    word_sel = word02_i;
         4'd3:    word_sel = word03_i;
         4'd4:    word_sel = word04_i;
         4'd5:    word_sel = word05_i;
         default: word_sel = '0;   // words 6 to 15 unused
      endcase
   end

   // ack drops after one cycle so a held strobe gets a single ack
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i[1] ? word_sel[31:16] : word_sel[15:0];   // adr[1] picks the half
   end

endmodule

//--- src/u1e_ctrl_top.sv
// u1e control core top: wishbone decode, misc registers, settings bus, time, readback
`include "u1e_ctrl_config.svh"

module u1e_ctrl_top
   import ctrl_bus_pkg::*, ctrl_regs_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   input  wb_adr_t    wb_adr_i,
   input  wb_dat_t    wb_dat_i,
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   input  logic       pps_i,
   input  misc_reg_t  rx_frame_len_i,
   output wb_dat_t    wb_dat_o,
   output logic       wb_ack_o,
   output logic [3:0] debug_led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output misc_reg_t  tx_frame_len_o,
   output logic [7:0] test_rate_o,
   output logic [3:0] test_ctrl_o
);
   logic       misc_stb, rb_stb, set_slv_stb;
   wb_dat_t    misc_dat, rb_dat;
   logic       misc_ack, rb_ack, set_ack;

   logic       set_stb;        // one cycle settings strobe
   set_adr_t   set_adr;
   set_dat_t   set_dat;

   set_dat_t   reg_test32;
   vita_time_t vita_time, vita_time_pps;

   //////////////////////////////////////////////////
   // wishbone intercon, single master

   wb_slave_decode wb_slave_decode_inst
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .adr_i(wb_adr_i),
      .misc_dat_i(misc_dat), .misc_ack_i(misc_ack),
      .rb_dat_i(rb_dat), .rb_ack_i(rb_ack), .set_ack_i(set_ack),
      .misc_stb_o(misc_stb), .rb_stb_o(rb_stb), .set_stb_o(set_slv_stb),
      .dat_o(wb_dat_o), .ack_o(wb_ack_o)
   );

   misc_regs misc_regs_inst   // slave 0
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .dat_o(misc_dat), .ack_o(misc_ack), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .tx_frame_len_o(tx_frame_len_o), .test_rate_o(test_rate_o), .test_ctrl_o(test_ctrl_o)
   );

   //////////////////////////////////////////////////
   // settings bus, slaves 8 and 9

   settings_bus_16le settings_bus_16le_inst
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(set_slv_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(set_ack), .set_stb_o(set_stb), .set_adr_o(set_adr), .set_dat_o(set_dat)
   );

   // persists over wb_rst, software uses it to see the fpga is still loaded
   setting_reg #(.my_addr(`SR_REG_TEST32), .width(32)) sr_reg_test32
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_adr_i(set_adr), .set_dat_i(set_dat),
      .out_o(reg_test32), .changed_o()
   );

   time_64bit time_64bit_inst
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_adr_i(set_adr), .set_dat_i(set_dat), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   //////////////////////////////////////////////////
   // readback mux, slave 7

   readback_mux_16le readback_mux_16le_inst
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(rb_stb), .adr_i(wb_adr_i),
      .word00_i(vita_time[63:32]), .word01_i(vita_time[31:0]),
      .word02_i(vita_time_pps[63:32]), .word03_i(vita_time_pps[31:0]),
      .word04_i(reg_test32),
      .word05_i('0),   // err_status, no error source left
      .dat_o(rb_dat), .ack_o(rb_ack)
   );

endmodule

//--- tb/u1e_ctrl_checker.sv
// bus handshake checker: ack follows stb, single cycle settings strobe, quiet after reset
module u1e_ctrl_checker
(
   input logic wb_clk,
   input logic wb_rst,
   input logic stb,
   input logic ack,
   input logic set_stb
);

   ack_needs_stb: assert property (@(posedge wb_clk) disable iff (wb_rst) ack |-> stb)
      else $error("ack seen without a strobe");

   // settings strobe lasts exactly one cycle
   set_stb_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
                                    set_stb |=> !set_stb)
      else $error("settings strobe held for two cycles");

   ack_low_after_reset: assert property (@(posedge wb_clk) $fell(wb_rst) |-> !ack)
      else $error("ack high in the first cycle after reset");

endmodule

bind wb_slave_decode u1e_ctrl_checker decode_checker
(
   .wb_clk(wb_clk), .wb_rst(wb_rst), .stb(cyc_i & stb_i), .ack(ack_o), .set_stb(set_stb_o)
);

bind settings_bus_16le u1e_ctrl_checker set_bus_checker
(
   .wb_clk(wb_clk), .wb_rst(wb_rst), .stb(stb_i), .ack(ack_o), .set_stb(set_stb_o)
);

//--- tb/u1e_ctrl_tb.sv
// u1e control core testbench: table driven wishbone stimulus with compare tasks
`include "u1e_ctrl_config.svh"

module u1e_ctrl_tb
   import ctrl_bus_pkg::*, ctrl_regs_pkg::*;
;
   localparam int OP_WR       = 0;
   localparam int OP_RD       = 1;
   localparam int OP_RD_RANGE = 2;   // exp holds the upper bound, value must be nonzero
   localparam int OP_LED      = 3;
   localparam int OP_CGEN     = 4;
   localparam int OP_TXLEN    = 5;
   localparam int OP_RATE     = 6;
   localparam int OP_CTRL     = 7;
   localparam int OP_STATUS   = 8;   // drive cgen status inputs from wdat
   localparam int OP_PPS      = 9;   // raise pps, then idle wdat cycles
   localparam int OP_IDLE     = 10;
   localparam int ACK_TIMEOUT = 100;
   localparam misc_reg_t RX_LEN = 16'h05DC;

   logic       wb_clk, wb_rst;
   logic       wb_cyc_i, wb_stb_i, wb_we_i;
   wb_adr_t    wb_adr_i;
   wb_dat_t    wb_dat_i, wb_dat_o;
   logic       wb_ack_o;
   logic       cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i, pps_i;
   misc_reg_t  rx_frame_len_i, tx_frame_len_o;
   logic [3:0] debug_led_o, test_ctrl_o;
   logic       cgen_sync_b_o, cgen_ref_sel_o;
   logic [7:0] test_rate_o;

   int         seed = 32'h3186_7740;
   wb_dat_t    leds_val, test_val, txlen_val, rate_val;
   set_dat_t   t32_val, time_hi;

   // stimulus table
   int         op_q[$];
   wb_adr_t    adr_q[$];
   wb_dat_t    wdat_q[$];
   wb_dat_t    exp_q[$];
   string      name_q[$];

   u1e_ctrl_top u1e_ctrl_top_inst (.*);

   initial
   begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////
   // reporting and compare

   task automatic end_in_failure();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
      if (act !== exp)
      begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         end_in_failure();
      end
   endtask

   task automatic check_led(input string name, input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp)
      begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         end_in_failure();
      end
   endtask

   ////////////////////////////////////////////////
   // bus tasks

   // ack is sampled at the falling edge, the master lets go at the next rising edge
   task automatic wb_transfer(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
      int   cnt;
      logic got;
      cnt = 0;
      got = 1'b0;
      rdat = '0;
      @(posedge wb_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      while (!got && cnt < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         if (wb_ack_o)
         begin
            got  = 1'b1;
            rdat = wb_dat_o;
         end
         else
            cnt++;
      end
      if (!got)
      begin
         $display("timeout: no ack from the bus for address %h", adr);
         end_in_failure();
      end
      @(posedge wb_clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      wb_transfer(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      wb_transfer(1'b0, adr, '0, dat);
   endtask

   task automatic idle_cycles(input wb_dat_t n);
      for (int c = 0; c < int'(n); c++)
         @(posedge wb_clk);
   endtask

   ////////////////////////////////////////////////
   // addresses and table

   function automatic wb_adr_t misc_addr(input logic [6:0] offset);
      return {`U1E_SLV_MISC, offset};
   endfunction

   function automatic wb_adr_t set_addr(input int idx, input logic hi);
      set_adr_t sidx;
      sidx = set_adr_t'(idx);
      return {`U1E_SLV_SET, 7'd0} | {3'd0, sidx, hi, 1'b0};   // index bit 5 lands in slave 9
   endfunction

   function automatic wb_adr_t rb_addr(input logic [3:0] word, input logic hi);
      return {`U1E_SLV_RB, 1'b0, word, hi, 1'b0};
   endfunction

   function automatic wb_dat_t port_value(input int op);
      case (op)
         OP_CGEN:  return {14'd0, cgen_sync_b_o, cgen_ref_sel_o};
         OP_TXLEN: return tx_frame_len_o;
         OP_RATE:  return {8'd0, test_rate_o};
         default:  return {12'd0, test_ctrl_o};
      endcase
   endfunction

   task automatic add_step(input int op, input wb_adr_t adr, input wb_dat_t wdat,
                           input wb_dat_t exp, input string name);
      op_q.push_back(op);
      adr_q.push_back(adr);
      wdat_q.push_back(wdat);
      exp_q.push_back(exp);
      name_q.push_back(name);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      rnd = $random(seed);
      leds_val = rnd[15:0];
      test_val = rnd[31:16];
      rnd = $random(seed);
      txlen_val = rnd[15:0];
      rate_val  = rnd[31:16];
      t32_val = $random(seed);
      time_hi = $random(seed);
      time_hi = time_hi | 32'h1;   // keep the loaded high word nonzero

      add_step(OP_LED,  '0, '0, 16'hF, "leds after reset");
      add_step(OP_CGEN, '0, '0, 16'h3, "cgen outputs after reset");
      add_step(OP_RD, misc_addr(`REG_COMPAT), '0, 16'd5, "compat number");
      add_step(OP_STATUS, '0, 16'h6, '0, "drive cgen status");
      add_step(OP_RD, misc_addr(`REG_CGEN_ST), '0, 16'h6, "cgen status");
      add_step(OP_RD, misc_addr(`REG_RX_FRAMELEN), '0, RX_LEN, "rx frame length");

      add_step(OP_WR, misc_addr(`REG_LEDS), leds_val, '0, "write leds");
      add_step(OP_RD, misc_addr(`REG_LEDS), '0, leds_val, "read leds");
      add_step(OP_LED, '0, '0, {12'd0, ~leds_val[3:0]}, "led outputs");
      add_step(OP_WR, misc_addr(`REG_TEST), test_val, '0, "write test");
      add_step(OP_RD, misc_addr(`REG_TEST), '0, test_val, "read test");
      add_step(OP_WR, misc_addr(`REG_TX_FRAMELEN), txlen_val, '0, "write tx frame length");
      add_step(OP_RD, misc_addr(`REG_TX_FRAMELEN), '0, txlen_val, "read tx frame length");
      add_step(OP_TXLEN, '0, '0, txlen_val, "tx frame length output");
      add_step(OP_WR, misc_addr(`REG_XFER_RATE), rate_val, '0, "write xfer rate");
      add_step(OP_RD, misc_addr(`REG_XFER_RATE), '0, rate_val, "read xfer rate");
      add_step(OP_RATE, '0, '0, {8'd0, rate_val[7:0]}, "test rate output");
      add_step(OP_CTRL, '0, '0, {12'd0, rate_val[11:8]}, "test ctrl output");
      add_step(OP_RD, misc_addr(7'd2), '0, 16'hBEEF, "unused misc offset");

      add_step(OP_WR, set_addr(`SR_REG_TEST32, 1'b0), t32_val[15:0], '0, "test32 low write");
      add_step(OP_WR, set_addr(`SR_REG_TEST32, 1'b1), t32_val[31:16], '0, "test32 high write");
      add_step(OP_RD, rb_addr(4'd4, 1'b0), '0, t32_val[15:0], "test32 low read");
      add_step(OP_RD, rb_addr(4'd4, 1'b1), '0, t32_val[31:16], "test32 high read");

      add_step(OP_WR, set_addr(`SR_TIME64, 1'b0), time_hi[15:0], '0, "time high, low half");
      add_step(OP_WR, set_addr(`SR_TIME64, 1'b1), time_hi[31:16], '0, "time high, high half");
      add_step(OP_WR, set_addr(`SR_TIME64 + 1, 1'b0), '0, '0, "time low, low half");
      add_step(OP_WR, set_addr(`SR_TIME64 + 1, 1'b1), '0, '0, "time low, high half");
      add_step(OP_IDLE, '0, 16'd4, '0, "wait for time load");
      add_step(OP_RD, rb_addr(4'd0, 1'b0), '0, time_hi[15:0], "time word 0 low");
      add_step(OP_RD, rb_addr(4'd0, 1'b1), '0, time_hi[31:16], "time word 0 high");
      add_step(OP_RD, rb_addr(4'd1, 1'b1), '0, 16'h0, "time word 1 high");
      add_step(OP_RD_RANGE, rb_addr(4'd1, 1'b0), '0, 16'd1000, "time word 1 low");

      add_step(OP_PPS, '0, 16'd10, '0, "raise pps");
      add_step(OP_RD, rb_addr(4'd2, 1'b0), '0, time_hi[15:0], "pps word 2 low");
      add_step(OP_RD, rb_addr(4'd2, 1'b1), '0, time_hi[31:16], "pps word 2 high");
      add_step(OP_RD, rb_addr(4'd3, 1'b1), '0, 16'h0, "pps word 3 high");
      add_step(OP_RD_RANGE, rb_addr(4'd3, 1'b0), '0, 16'd1000, "pps word 3 low");
   endtask

   ////////////////////////////////////////////////
   // main sequence

   initial
   begin
      wb_dat_t rd;
      wb_rst           <= 1'b1;
      wb_cyc_i         <= 1'b0;
      wb_stb_i         <= 1'b0;
      wb_we_i          <= 1'b0;
      wb_adr_i         <= '0;
      wb_dat_i         <= '0;
      cgen_st_status_i <= 1'b0;
      cgen_st_ld_i     <= 1'b0;
      cgen_st_refmon_i <= 1'b0;
      pps_i            <= 1'b0;
      rx_frame_len_i   <= RX_LEN;
      build_table();
      repeat (16) @(posedge wb_clk);
      wb_rst <= 1'b0;

      for (int i = 0; i < op_q.size(); i++)
      begin
         case (op_q[i])
            OP_WR: wb_write(adr_q[i], wdat_q[i]);
            OP_RD:
            begin
               wb_read(adr_q[i], rd);
               check_dat(name_q[i], exp_q[i], rd);
            end
            OP_RD_RANGE:
            begin
               wb_read(adr_q[i], rd);
               if (rd == 16'd0 || rd >= exp_q[i])
               begin
                  $display("%s: read value %0d is not between 1 and %0d", name_q[i], rd,
                           exp_q[i] - 16'd1);
                  end_in_failure();
               end
            end
            OP_LED:
            begin
               @(negedge wb_clk);
               check_led(name_q[i], exp_q[i][3:0], debug_led_o);
            end
            OP_CGEN, OP_TXLEN, OP_RATE, OP_CTRL:
            begin
               @(negedge wb_clk);   // registers settled
               check_dat(name_q[i], exp_q[i], port_value(op_q[i]));
            end
            OP_STATUS:
            begin
               @(posedge wb_clk);
               {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} <= wdat_q[i][2:0];
            end
            OP_PPS:
            begin
               @(posedge wb_clk);
               pps_i <= 1'b1;
               idle_cycles(wdat_q[i]);
            end
            default: idle_cycles(wdat_q[i]);
         endcase
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+src
src/ctrl_bus_pkg.sv
src/ctrl_regs_pkg.sv
src/setting_reg.sv
src/wb_slave_decode.sv
src/misc_regs.sv
src/settings_bus_16le.sv
src/time_64bit.sv
src/readback_mux_16le.sv
src/u1e_ctrl_top.sv
tb/u1e_ctrl_checker.sv
tb/u1e_ctrl_tb.sv

//--- Makefile
TOP = u1e_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	rm -f sim.log
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim 2>&1 | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
